/* rv32i_pkg.sv */
// RV32I core shared definitions
// Widths, opcodes, function codes and the decode enumerations
`default_nettype none

package rv32i_pkg;

  // Data path and register file
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Data memory size in words
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_t;

  // funct3 codes
  localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub and addi
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw
  localparam logic [2:0] F3_BEQ  = 3'b000;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_t;

  // Immediate formats
  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_S = 2'd1,
    IMM_B = 2'd2
  } imm_sel_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
// Fetch stage
// Program counter with branch redirect and the fetch-to-decode register
`default_nettype none

module fetch_stage
  import rv32i_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            branch_taken,
  input  logic [XLEN-1:0] branch_target,
  output logic [XLEN-1:0] imem_addr,
  input  logic [XLEN-1:0] imem_rdata,
  output logic [XLEN-1:0] instr_d,
  output logic [XLEN-1:0] pc_d
);

  logic [XLEN-1:0] pc;

  assign imem_addr = pc;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (branch_taken)
      pc <= branch_target;
    else
      pc <= pc + XLEN'(4);
  end

  // Wrong-path word becomes a nop on a taken branch
  always_ff @(posedge clk)
  begin
    if (reset || branch_taken)
      instr_d <= NOP_INSTR;
    else
      instr_d <= imem_rdata;
    pc_d <= pc;
  end

  a_imem_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* control_unit.sv */
// Main decoder
// Splits an instruction into fields and derives controls and the ALU operation
`default_nettype none

module control_unit
  import rv32i_pkg::*;
(
  input  logic [XLEN-1:0]   instr,
  output logic [REG_AW-1:0] rs1,
  output logic [REG_AW-1:0] rs2,
  output logic [REG_AW-1:0] rd,
  output logic              regwrite,
  output logic              memwrite,
  output logic              resultsrc,
  output logic              alusrc,
  output logic              branch,
  output alu_op_t           alu_ctrl,
  output imm_sel_t          imm_sel
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rd       = instr[11:7];

  always_comb
  begin
    // Anything unrecognised falls through as a nop
    regwrite  = 1'b0;
    memwrite  = 1'b0;
    resultsrc = 1'b0;
    alusrc    = 1'b0;
    branch    = 1'b0;
    alu_ctrl  = ALU_ADD;
    imm_sel   = IMM_I;
    case (opcode)
      OP_R:
      begin
        regwrite = 1'b1;
        case (funct3)
          F3_ADD: alu_ctrl = funct7b5 ? ALU_SUB : ALU_ADD;
          F3_SLT: alu_ctrl = ALU_SLT;
          F3_OR:  alu_ctrl = ALU_OR;
          F3_AND: alu_ctrl = ALU_AND;
          default: regwrite = 1'b0;
        endcase
      end
      OP_IMM:
      begin
        regwrite = (funct3 == F3_ADD);
        alusrc   = 1'b1;
      end
      OP_LOAD:
      begin
        regwrite  = (funct3 == F3_WORD);
        resultsrc = 1'b1;
        alusrc    = 1'b1;
      end
      OP_STORE:
      begin
        memwrite = (funct3 == F3_WORD);
        alusrc   = 1'b1;
        imm_sel  = IMM_S;
      end
      OP_BRANCH:
      begin
        // Compare by subtraction
        branch   = (funct3 == F3_BEQ);
        alu_ctrl = ALU_SUB;
        imm_sel  = IMM_B;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* reg_file.sv */
// Integer register file
// 32 x 32-bit, two read ports, one write port, x0 hardwired to zero
`default_nettype none

module reg_file
  import rv32i_pkg::*;
(
  input  logic              clk,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  output logic [XLEN-1:0]   rd1,
  output logic [XLEN-1:0]   rd2,
  input  logic              we,
  input  logic [REG_AW-1:0] wa,
  input  logic [XLEN-1:0]   wd
);

  // No storage behind x0
  logic [XLEN-1:0] regs [1:(2**REG_AW)-1];

  // Same-cycle write is returned to the reader
  function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    else if (we && (wa == addr))
      return wd;
    else
      return regs[addr];
  endfunction

  always_ff @(posedge clk)
  begin
    if (we && (wa != '0))
      regs[wa] <= wd;
  end

  always_comb
  begin
    rd1 = read_reg(rs1);
    rd2 = read_reg(rs2);
  end

  // A written value is held for the next read of that register
  a_write_held: assert property (@(posedge clk) (we && (wa != '0)) |=>
    (rs1 != $past(wa)) || (we && (wa == rs1)) || (rd1 == $past(wd)));

endmodule

`default_nettype wire

/* decode_stage.sv */
// Decode stage
// Control decode, register read and immediate extension into the execute register
`default_nettype none

module decode_stage
  import rv32i_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [XLEN-1:0]   instr_d,
  input  logic [XLEN-1:0]   pc_d,
  input  logic              regwrite_w,
  input  logic [REG_AW-1:0] rd_w,
  input  logic [XLEN-1:0]   result_w,
  input  logic              branch_taken,
  output logic              regwrite_e,
  output logic              memwrite_e,
  output logic              resultsrc_e,
  output logic              alusrc_e,
  output logic              branch_e,
  output alu_op_t           alu_ctrl_e,
  output logic [XLEN-1:0]   src_a_e,
  output logic [XLEN-1:0]   rd2_e,
  output logic [XLEN-1:0]   imm_e,
  output logic [REG_AW-1:0] rd_e,
  output logic [XLEN-1:0]   pc_e
);

  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd_d;
  logic              regwrite_d;
  logic              memwrite_d;
  logic              resultsrc_d;
  logic              alusrc_d;
  logic              branch_d;
  alu_op_t           alu_ctrl_d;
  imm_sel_t          imm_sel;
  logic [XLEN-1:0]   rd1;
  logic [XLEN-1:0]   rd2;
  logic [XLEN-1:0]   imm_d;

  control_unit i_control_unit (
    .instr     (instr_d),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd_d),
    .regwrite  (regwrite_d),
    .memwrite  (memwrite_d),
    .resultsrc (resultsrc_d),
    .alusrc    (alusrc_d),
    .branch    (branch_d),
    .alu_ctrl  (alu_ctrl_d),
    .imm_sel   (imm_sel)
  );

  reg_file i_reg_file (
    .clk (clk),
    .rs1 (rs1),
    .rs2 (rs2),
    .rd1 (rd1),
    .rd2 (rd2),
    .we  (regwrite_w),
    .wa  (rd_w),
    .wd  (result_w)
  );

  // Sign-extended immediate
  always_comb
  begin
    case (imm_sel)
      IMM_I: imm_d = {{(XLEN-12){instr_d[31]}}, instr_d[31:20]};
      IMM_S: imm_d = {{(XLEN-12){instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
      IMM_B: imm_d = {{(XLEN-13){instr_d[31]}}, instr_d[31], instr_d[7],
                      instr_d[30:25], instr_d[11:8], 1'b0};
      default: imm_d = '0;
    endcase
  end

  // Flush turns the instruction in decode into a bubble
  always_ff @(posedge clk)
  begin
    if (reset || branch_taken)
    begin
      regwrite_e  <= 1'b0;
      memwrite_e  <= 1'b0;
      resultsrc_e <= 1'b0;
      alusrc_e    <= 1'b0;
      branch_e    <= 1'b0;
      alu_ctrl_e  <= ALU_ADD;
    end
    else
    begin
      regwrite_e  <= regwrite_d;
      memwrite_e  <= memwrite_d;
      resultsrc_e <= resultsrc_d;
      alusrc_e    <= alusrc_d;
      branch_e    <= branch_d;
      alu_ctrl_e  <= alu_ctrl_d;
    end
  end

  always_ff @(posedge clk)
  begin
    src_a_e <= rd1;
    rd2_e   <= rd2;
    imm_e   <= imm_d;
    rd_e    <= rd_d;
    pc_e    <= pc_d;
  end

endmodule

`default_nettype wire

/* execute_stage.sv */
// Execute stage
// ALU, beq decision and target, and the execute-to-memory register
`default_nettype none

module execute_stage
  import rv32i_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              regwrite_e,
  input  logic              memwrite_e,
  input  logic              resultsrc_e,
  input  logic              alusrc_e,
  input  logic              branch_e,
  input  alu_op_t           alu_ctrl_e,
  input  logic [XLEN-1:0]   src_a_e,
  input  logic [XLEN-1:0]   rd2_e,
  input  logic [XLEN-1:0]   imm_e,
  input  logic [REG_AW-1:0] rd_e,
  input  logic [XLEN-1:0]   pc_e,
  output logic              branch_taken,
  output logic [XLEN-1:0]   branch_target,
  output logic [XLEN-1:0]   alu_result_m,
  output logic [XLEN-1:0]   write_data_m,
  output logic [REG_AW-1:0] rd_m,
  output logic              regwrite_m,
  output logic              memwrite_m,
  output logic              resultsrc_m
);

  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_result;

  assign src_b = alusrc_e ? imm_e : rd2_e;

  always_comb
  begin
    case (alu_ctrl_e)
      ALU_ADD: alu_result = src_a_e + src_b;
      ALU_SUB: alu_result = src_a_e - src_b;
      ALU_AND: alu_result = src_a_e & src_b;
      ALU_OR:  alu_result = src_a_e | src_b;
      ALU_SLT: alu_result = XLEN'($signed(src_a_e) < $signed(src_b));
      default: alu_result = '0;
    endcase
  end

  // beq is taken on equal operands
  assign branch_taken  = branch_e && (alu_result == '0);
  assign branch_target = pc_e + imm_e;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regwrite_m  <= 1'b0;
      memwrite_m  <= 1'b0;
      resultsrc_m <= 1'b0;
    end
    else
    begin
      regwrite_m  <= regwrite_e;
      memwrite_m  <= memwrite_e;
      resultsrc_m <= resultsrc_e;
    end
  end

  always_ff @(posedge clk)
  begin
    alu_result_m <= alu_result;
    write_data_m <= rd2_e;
    rd_m         <= rd_e;
  end

  // The slot after a taken beq arrives here as a bubble
  a_branch_flush: assert property (@(posedge clk) disable iff (reset)
    branch_taken |=> (!branch_e && !regwrite_e && !memwrite_e));

endmodule

`default_nettype wire

/* memory_stage.sv */
// Memory stage
// Word data memory for lw and sw, result select and the writeback register
`default_nettype none

module memory_stage
  import rv32i_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [XLEN-1:0]   alu_result_m,
  input  logic [XLEN-1:0]   write_data_m,
  input  logic [REG_AW-1:0] rd_m,
  input  logic              regwrite_m,
  input  logic              memwrite_m,
  input  logic              resultsrc_m,
  output logic              regwrite_w,
  output logic [REG_AW-1:0] rd_w,
  output logic [XLEN-1:0]   result_w
);

  logic [XLEN-1:0]    dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_addr;
  logic [XLEN-1:0]    read_data;
  logic [XLEN-1:0]    result_m;

  // Byte address to word index
  assign word_addr = alu_result_m[DMEM_AW+1:2];
  assign read_data = dmem[word_addr];
  assign result_m  = resultsrc_m ? read_data : alu_result_m;

  always_ff @(posedge clk)
  begin
    if (memwrite_m)
      dmem[word_addr] <= write_data_m;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      regwrite_w <= 1'b0;
    else
      regwrite_w <= regwrite_m;
    rd_w     <= rd_m;
    result_w <= result_m;
  end

  a_dmem_range: assert property (@(posedge clk) disable iff (reset)
    (memwrite_m || resultsrc_m) |-> (alu_result_m[XLEN-1:2] < DMEM_WORDS));

endmodule

`default_nettype wire

/* rv32i_core.sv */
// RV32I integer core
// Four pipeline stages around the decode stage, with instruction bus and writeback trace
`default_nettype none

module rv32i_core
  import rv32i_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  output logic [XLEN-1:0]   imem_addr,
  input  logic [XLEN-1:0]   imem_rdata,
  output logic              wb_valid,
  output logic [REG_AW-1:0] wb_rd,
  output logic [XLEN-1:0]   wb_data
);

  // Fetch to decode
  logic [XLEN-1:0]   instr_d;
  logic [XLEN-1:0]   pc_d;

  // Decode to execute
  logic              regwrite_e;
  logic              memwrite_e;
  logic              resultsrc_e;
  logic              alusrc_e;
  logic              branch_e;
  alu_op_t           alu_ctrl_e;
  logic [XLEN-1:0]   src_a_e;
  logic [XLEN-1:0]   rd2_e;
  logic [XLEN-1:0]   imm_e;
  logic [REG_AW-1:0] rd_e;
  logic [XLEN-1:0]   pc_e;

  // Branch redirect
  logic              branch_taken;
  logic [XLEN-1:0]   branch_target;

  // Execute to memory
  logic [XLEN-1:0]   alu_result_m;
  logic [XLEN-1:0]   write_data_m;
  logic [REG_AW-1:0] rd_m;
  logic              regwrite_m;
  logic              memwrite_m;
  logic              resultsrc_m;

  // Writeback
  logic              regwrite_w;
  logic [REG_AW-1:0] rd_w;
  logic [XLEN-1:0]   result_w;

  fetch_stage i_fetch_stage (
    .clk           (clk),
    .reset         (reset),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .imem_addr     (imem_addr),
    .imem_rdata    (imem_rdata),
    .instr_d       (instr_d),
    .pc_d          (pc_d)
  );

  decode_stage i_decode_stage (
    .clk          (clk),
    .reset        (reset),
    .instr_d      (instr_d),
    .pc_d         (pc_d),
    .regwrite_w   (regwrite_w),
    .rd_w         (rd_w),
    .result_w     (result_w),
    .branch_taken (branch_taken),
    .regwrite_e   (regwrite_e),
    .memwrite_e   (memwrite_e),
    .resultsrc_e  (resultsrc_e),
    .alusrc_e     (alusrc_e),
    .branch_e     (branch_e),
    .alu_ctrl_e   (alu_ctrl_e),
    .src_a_e      (src_a_e),
    .rd2_e        (rd2_e),
    .imm_e        (imm_e),
    .rd_e         (rd_e),
    .pc_e         (pc_e)
  );

  execute_stage i_execute_stage (
    .clk           (clk),
    .reset         (reset),
    .regwrite_e    (regwrite_e),
    .memwrite_e    (memwrite_e),
    .resultsrc_e   (resultsrc_e),
    .alusrc_e      (alusrc_e),
    .branch_e      (branch_e),
    .alu_ctrl_e    (alu_ctrl_e),
    .src_a_e       (src_a_e),
    .rd2_e         (rd2_e),
    .imm_e         (imm_e),
    .rd_e          (rd_e),
    .pc_e          (pc_e),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .alu_result_m  (alu_result_m),
    .write_data_m  (write_data_m),
    .rd_m          (rd_m),
    .regwrite_m    (regwrite_m),
    .memwrite_m    (memwrite_m),
    .resultsrc_m   (resultsrc_m)
  );

  memory_stage i_memory_stage (
    .clk          (clk),
    .reset        (reset),
    .alu_result_m (alu_result_m),
    .write_data_m (write_data_m),
    .rd_m         (rd_m),
    .regwrite_m   (regwrite_m),
    .memwrite_m   (memwrite_m),
    .resultsrc_m  (resultsrc_m),
    .regwrite_w   (regwrite_w),
    .rd_w         (rd_w),
    .result_w     (result_w)
  );

  // Writes to x0 are not reported
  assign wb_valid = regwrite_w && (rd_w != '0);
  assign wb_rd    = rd_w;
  assign wb_data  = result_w;

endmodule

`default_nettype wire

/* tb_rv32i_core.sv */
// Testbench for the RV32I core
// Serves instructions from a small memory and checks the writeback trace of each program
`default_nettype none

module tb_rv32i_core
  import rv32i_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = 40;
  localparam int DRAIN_CYCLES = 8;
  localparam int NUM_TESTS    = 4;
  localparam int MAX_INSTR    = 16;
  localparam int MAX_WB       = 10;
  localparam int IMEM_AW      = 5;
  localparam int IMEM_WORDS   = 2**IMEM_AW;
  // Longest one test can take, with a little margin
  localparam int TEST_CYCLES  = RESET_CYCLES + CYCLE_LIMIT + DRAIN_CYCLES + 4;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

  logic              clk;
  logic              reset;
  logic [XLEN-1:0]   imem_addr;
  logic [XLEN-1:0]   imem_rdata;
  logic              wb_valid;
  logic [REG_AW-1:0] wb_rd;
  logic [XLEN-1:0]   wb_data;

  logic [XLEN-1:0]   imem [IMEM_WORDS];

  // Programs and their expected writebacks
  string             test_name   [NUM_TESTS];
  logic [XLEN-1:0]   prog_tab    [NUM_TESTS][MAX_INSTR];
  int                prog_len    [NUM_TESTS];
  logic [REG_AW-1:0] exp_rd_tab  [NUM_TESTS][MAX_WB];
  logic [XLEN-1:0]   exp_val_tab [NUM_TESTS][MAX_WB];
  int                exp_cnt     [NUM_TESTS];

  // Writebacks seen in the running test
  logic [REG_AW-1:0] got_rd   [$];
  logic [XLEN-1:0]   got_val  [$];
  time               got_time [$];

  int test_errors;
  int total_errors;
  int tests_failed;

  rv32i_core i_rv32i_core (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

  // Past the end of the array the core only sees nops
  assign imem_rdata = (imem_addr < XLEN'(IMEM_WORDS * 4)) ? imem[imem_addr[IMEM_AW+1:2]]
                                                         : NOP_WORD;

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Instruction encoders, straight from the RV32I formats
  function automatic logic [XLEN-1:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [XLEN-1:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [XLEN-1:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [XLEN-1:0] beq(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [XLEN-1:0] r_op(input logic alt, input logic [2:0] f3, input int rd,
                                           input int rs1, input int rs2);
    return {1'b0, alt, 5'b00000, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  task automatic add_instr(input int t, input logic [XLEN-1:0] word);
    prog_tab[t][prog_len[t]] = word;
    prog_len[t]++;
  endtask

  task automatic expect_wb(input int t, input int rd, input int value);
    exp_rd_tab[t][exp_cnt[t]]  = rd[REG_AW-1:0];
    exp_val_tab[t][exp_cnt[t]] = value;
    exp_cnt[t]++;
  endtask

  task automatic build_tests();
    int t;
    for (t = 0; t < NUM_TESTS; t++)
    begin
      prog_len[t] = 0;
      exp_cnt[t]  = 0;
    end

    // Consumer exactly three slots after its producer
    test_name[0] = "addi chain";
    add_instr(0, addi(1, 0, 5));
    add_instr(0, NOP_WORD);
    add_instr(0, NOP_WORD);
    add_instr(0, addi(2, 1, 7));
    add_instr(0, addi(0, 1, 9));
    add_instr(0, NOP_WORD);
    add_instr(0, addi(3, 2, -20));
    expect_wb(0, 1, 5);
    expect_wb(0, 2, 12);
    expect_wb(0, 3, -8);

    test_name[1] = "r-type alu";
    add_instr(1, addi(1, 0, 12));
    add_instr(1, addi(2, 0, 10));
    add_instr(1, addi(3, 0, -3));
    add_instr(1, NOP_WORD);
    add_instr(1, NOP_WORD);
    add_instr(1, r_op(1'b0, 3'b000, 4, 1, 2));  // add
    add_instr(1, r_op(1'b1, 3'b000, 5, 2, 1));  // sub
    add_instr(1, r_op(1'b0, 3'b111, 6, 1, 2));  // and
    add_instr(1, r_op(1'b0, 3'b110, 7, 1, 2));  // or
    add_instr(1, r_op(1'b0, 3'b010, 8, 3, 1));  // slt, -3 < 12
    add_instr(1, r_op(1'b0, 3'b010, 9, 1, 3));  // slt, 12 < -3 is false
    expect_wb(1, 1, 12);
    expect_wb(1, 2, 10);
    expect_wb(1, 3, -3);
    expect_wb(1, 4, 22);
    expect_wb(1, 5, -2);
    expect_wb(1, 6, 8);
    expect_wb(1, 7, 14);
    expect_wb(1, 8, 1);
    expect_wb(1, 9, 0);

    // Words 4 and 6, read back in reverse order
    test_name[2] = "load store";
    add_instr(2, addi(5, 0, 16));
    add_instr(2, addi(1, 0, 291));
    add_instr(2, addi(2, 0, -77));
    add_instr(2, NOP_WORD);
    add_instr(2, sw(1, 5, 0));
    add_instr(2, sw(2, 5, 8));
    add_instr(2, lw(3, 5, 8));
    add_instr(2, lw(4, 5, 0));
    add_instr(2, NOP_WORD);
    add_instr(2, NOP_WORD);
    add_instr(2, r_op(1'b0, 3'b000, 6, 3, 4));
    expect_wb(2, 5, 16);
    expect_wb(2, 1, 291);
    expect_wb(2, 2, -77);
    expect_wb(2, 3, -77);
    expect_wb(2, 4, 291);
    expect_wb(2, 6, 214);

    test_name[3] = "beq";
    add_instr(3, addi(1, 0, 4));
    add_instr(3, addi(2, 0, 4));
    add_instr(3, addi(3, 0, 9));
    add_instr(3, NOP_WORD);
    add_instr(3, NOP_WORD);
    add_instr(3, beq(1, 2, 12));  // taken, lands on slot 8
    add_instr(3, addi(10, 0, 1));
    add_instr(3, addi(11, 0, 2));
    add_instr(3, addi(12, 0, 3));
    add_instr(3, beq(1, 3, 12));  // not taken
    add_instr(3, addi(13, 0, 5));
    add_instr(3, addi(14, 0, 6));
    expect_wb(3, 1, 4);
    expect_wb(3, 2, 4);
    expect_wb(3, 3, 9);
    expect_wb(3, 12, 3);
    expect_wb(3, 13, 5);
    expect_wb(3, 14, 6);
  endtask

  task automatic load_program(input int t);
    int i;
    for (i = 0; i < IMEM_WORDS; i++)
    begin
      if (i < prog_len[t])
        imem[i] = prog_tab[t][i];
      else
        imem[i] = NOP_WORD;
    end
  endtask

  task automatic apply_reset();
    int i;
    for (i = 0; i < RESET_CYCLES; i++)
    begin
      @(negedge clk);
      // Writeback register and PC are clear after the first reset edge
      if (i > 0)
      begin
        assert (!wb_valid)
        else
        begin
          $display("writeback reported while reset is held, at %0t", $time);
          test_errors++;
        end
        assert (imem_addr == '0)
        else
        begin
          $display("error: %0t imem_addr expected %08h actual %08h", $time, 0, imem_addr);
          test_errors++;
        end
      end
      @(posedge clk);
    end
    #1;
    reset = 1'b0;
  endtask

  task automatic sample_writeback();
    @(negedge clk);
    if (wb_valid)
    begin
      got_rd.push_back(wb_rd);
      got_val.push_back(wb_data);
      got_time.push_back($time);
    end
  endtask

  task automatic run_test(input int t);
    int cyc;
    int i;
    int n;
    test_errors = 0;
    got_rd.delete();
    got_val.delete();
    got_time.delete();
    @(posedge clk);
    #1;
    reset = 1'b1;
    load_program(t);
    apply_reset();
    cyc = 0;
    while ((got_rd.size() < exp_cnt[t]) && (cyc < CYCLE_LIMIT))
    begin
      sample_writeback();
      cyc++;
    end
    // Catch late extra writebacks
    for (i = 0; i < DRAIN_CYCLES; i++)
      sample_writeback();
    assert (got_rd.size() == exp_cnt[t])
    else
    begin
      $display("test %0d expected %0d writebacks but saw %0d", t, exp_cnt[t], got_rd.size());
      test_errors++;
    end
    n = (got_rd.size() < exp_cnt[t]) ? got_rd.size() : exp_cnt[t];
    for (i = 0; i < n; i++)
    begin
      assert (got_rd[i] == exp_rd_tab[t][i])
      else
      begin
        $display("error: %0t wb_rd expected %0d actual %0d",
                 got_time[i], exp_rd_tab[t][i], got_rd[i]);
        test_errors++;
      end
      assert (got_val[i] == exp_val_tab[t][i])
      else
      begin
        $display("error: %0t wb_data expected %08h actual %08h",
                 got_time[i], exp_val_tab[t][i], got_val[i]);
        test_errors++;
      end
    end
    total_errors += test_errors;
    if (test_errors != 0)
      tests_failed++;
    $display("test %0d %0s: %0d writebacks, %0s", t, test_name[t], got_rd.size(),
             (test_errors == 0) ? "ok" : "FAILED");
  endtask

  initial
  begin
    int t;
    reset        = 1'b1;
    total_errors = 0;
    tests_failed = 0;
    build_tests();
    load_program(0);
    for (t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0t before all tests finished", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rv32i_pkg.sv
fetch_stage.sv
control_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv32i_core.sv
tb_rv32i_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_rv32i_core -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv32i_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
